// ==== project.f ====
source/axis2axi_pkg.sv
source/stream_fifo.sv
source/axi_burst_writer.sv
source/axis2axi_in.sv
dv/axi_mem_slave.sv
dv/tb_axis2axi_in.sv

// ==== Makefile ====
# Verilator build and run for the AXI-Stream to AXI write bridge

SOURCES := $(wildcard source/*.sv dv/*.sv)

.PHONY: all run clean

all: obj_dir/Vtb_axis2axi_in

obj_dir/Vtb_axis2axi_in: project.f $(SOURCES)
	verilator --binary --timing --assert --Mdir obj_dir \
		--top-module tb_axis2axi_in -o Vtb_axis2axi_in -f project.f

run: obj_dir/Vtb_axis2axi_in
	@out="$$(./obj_dir/Vtb_axis2axi_in)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== dv/tb_axis2axi_in.sv ====
`timescale 1ns/100ps

module tb_axis2axi_in import axis2axi_pkg::*; ();

   localparam int CLK_PERIOD   = 10;
   localparam int PHASE1_WORDS = 120;
   localparam int PHASE2_WORDS = 160;
   localparam int TOTAL_WORDS  = PHASE1_WORDS + PHASE2_WORDS;

   logic                  clk;
   logic                  rst_n;
   logic [AXI_ADDR_W-1:0] addr;
   logic                  set_config;
   logic [AXI_DATA_W-1:0] axis_data;
   logic                  axis_valid;
   logic                  axis_ready;
   axi_aw_t               aw;
   logic                  awvalid;
   logic                  awready;
   axi_w_t                w;
   logic                  wvalid;
   logic                  wready;
   logic                  bvalid;
   logic                  bready;
   logic                  busy;

   logic                  beat_rep;
   logic [AXI_ADDR_W-1:0] beat_addr;
   logic [AXI_DATA_W-1:0] beat_data;
   logic                  beat_last;
   logic                  burst_rep;
   logic [AXI_ADDR_W-1:0] burst_addr;
   logic [AXI_LEN_W-1:0]  burst_len;
   logic [8:0]            burst_beats;

   // Reference model state
   logic [AXI_DATA_W-1:0] exp_q [$];
   logic [AXI_ADDR_W-1:0] exp_addr;
   int                    errors;
   int                    words_checked;
   int                    bursts_checked;
   int                    accepted;
   int                    written;
   int                    phase;
   int                    cur_len;
   int                    beat_idx;
   logic                  b_outstanding;
   logic                  burst_flush;
   logic                  aw_prev;
   logic                  valid_d;

   axis2axi_in u_dut (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .addr_i       (addr),
      .set_config_i (set_config),
      .axis_data_i  (axis_data),
      .axis_valid_i (axis_valid),
      .axis_ready_o (axis_ready),
      .aw_o         (aw),
      .awvalid_o    (awvalid),
      .awready_i    (awready),
      .w_o          (w),
      .wvalid_o     (wvalid),
      .wready_i     (wready),
      .bvalid_i     (bvalid),
      .bready_o     (bready),
      .busy_o       (busy)
   );

   axi_mem_slave u_slave (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .aw_i          (aw),
      .awvalid_i     (awvalid),
      .awready_o     (awready),
      .w_i           (w),
      .wvalid_i      (wvalid),
      .wready_o      (wready),
      .bvalid_o      (bvalid),
      .bready_i      (bready),
      .beat_o        (beat_rep),
      .beat_addr_o   (beat_addr),
      .beat_data_o   (beat_data),
      .beat_last_o   (beat_last),
      .burst_o       (burst_rep),
      .burst_addr_o  (burst_addr),
      .burst_len_o   (burst_len),
      .burst_beats_o (burst_beats)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Watchdog
   initial begin
      #((200 * TOTAL_WORDS + 1000) * CLK_PERIOD);
      $display("Timeout: the run did not finish in %0d cycles", 200 * TOTAL_WORDS + 1000);
      $display("Result: FAILED");
      $finish;
   end

   task automatic compare_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         errors++;
         $display("Mismatch at %0t: %s = %0b, expected %0b", $time, name, actual, expected);
      end
   endtask

   task automatic check_reset_state();
      compare_bit("awvalid_o", awvalid, 1'b0);
      compare_bit("wvalid_o", wvalid, 1'b0);
      compare_bit("busy_o", busy, 1'b0);
      compare_bit("axis_ready_o", axis_ready, 1'b1);
   endtask

   task automatic check_beat();
      logic [AXI_DATA_W-1:0] exp_word;
      logic                  exp_last;
      if (exp_q.size() == 0) begin
         errors++;
         $display("Error at %0t: AXI beat %08h written with no stream word left", $time,
                  beat_data);
      end else begin
         exp_word = exp_q.pop_front();
         if (beat_data !== exp_word) begin
            errors++;
            $display("Mismatch at %0t: w_o.data = %08h, expected %08h", $time, beat_data,
                     exp_word);
         end
      end
      if (beat_addr !== exp_addr) begin
         errors++;
         $display("Mismatch at %0t: beat address = %08h, expected %08h", $time, beat_addr,
                  exp_addr);
      end
      exp_addr = exp_addr + 32'd4;
      exp_last = (beat_idx == cur_len);
      if (beat_last !== exp_last) begin
         errors++;
         $display("Mismatch at %0t: w_o.last = %0b, expected %0b", $time, beat_last, exp_last);
      end
      beat_idx = exp_last ? 0 : beat_idx + 1;
      words_checked++;
   endtask

   task automatic check_burst();
      int beats;
      int span;
      beats = int'(burst_beats);
      span  = int'(burst_addr[BOUNDARY_W-1:0]) + 4 * beats;
      bursts_checked++;
      if (beats < 1 || beats > BURST_SIZE) begin
         errors++;
         $display("Error at %0t: burst of %0d beats is out of range", $time, beats);
      end
      if (beats != int'(burst_len) + 1) begin
         errors++;
         $display("Mismatch at %0t: aw_o.len = %0d, expected %0d", $time, burst_len, beats - 1);
      end
      if (span > BOUNDARY_BYTES) begin
         errors++;
         $display("Error at %0t: burst at %08h crosses a 4 KB boundary", $time, burst_addr);
      end
      // Continuous stream only yields short bursts at a boundary or on a flush
      if (phase == 2 && beats != BURST_SIZE && !burst_flush && span != BOUNDARY_BYTES) begin
         errors++;
         $display("Error at %0t: short burst of %0d beats while streaming", $time, beats);
      end
   endtask

   // Monitor and reference model
   always @(posedge clk) begin
      if (rst_n) begin
         if (!axis_ready && (accepted - written) < BUFFER_SIZE) begin
            errors++;
            $display("Error at %0t: axis_ready_o low with only %0d words pending", $time,
                     accepted - written);
         end
         if (awvalid && b_outstanding) begin
            errors++;
            $display("Error at %0t: awvalid_o high before the previous write response", $time);
         end
         // Start condition was one cycle before awvalid rose
         if (awvalid && !aw_prev) begin
            burst_flush = !valid_d;
         end
         if (awvalid && awready) begin
            b_outstanding = 1'b1;
            cur_len       = int'(aw.len);
         end
         if (bvalid && bready) begin
            b_outstanding = 1'b0;
         end
         if (axis_valid && axis_ready) begin
            exp_q.push_back(axis_data);
            accepted++;
         end
         if (wvalid && wready) begin
            written++;
         end
         if (beat_rep) begin
            check_beat();
         end
         if (burst_rep) begin
            check_burst();
         end
         aw_prev = awvalid;
         valid_d = axis_valid;
      end
   end

   task automatic configure(input logic [AXI_ADDR_W-1:0] start_addr);
      while (busy) begin
         @(posedge clk);
      end
      set_config <= 1'b1;
      addr       <= start_addr;
      exp_addr    = start_addr;
      @(posedge clk);
      set_config <= 1'b0;
   endtask

   task automatic send_stream(input int n, input bit gaps);
      int i;
      int idle;
      for (i = 0; i < n; i++) begin
         if (gaps && $urandom_range(3, 0) == 0) begin
            axis_valid <= 1'b0;
            idle = $urandom_range(24, 1);
            repeat (idle) @(posedge clk);
         end
         axis_valid <= 1'b1;
         axis_data  <= $urandom;
         @(posedge clk);
         while (!axis_ready) begin
            @(posedge clk);
         end
      end
      axis_valid <= 1'b0;
   endtask

   // Idle long enough that every buffered word has been flushed
   task automatic wait_drain();
      int idle;
      idle = 0;
      while (idle < 20) begin
         @(posedge clk);
         idle = busy ? 0 : idle + 1;
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Error at %0t: %0d stream words never reached AXI", $time, exp_q.size());
      end
   endtask

   initial begin
      void'($urandom(76));
      rst_n          = 1'b0;
      addr           = '0;
      set_config     = 1'b0;
      axis_data      = '0;
      axis_valid     = 1'b0;
      exp_addr       = '0;
      errors         = 0;
      words_checked  = 0;
      bursts_checked = 0;
      accepted       = 0;
      written        = 0;
      phase          = 0;
      cur_len        = 0;
      beat_idx       = 0;
      b_outstanding  = 1'b0;
      burst_flush    = 1'b0;
      aw_prev        = 1'b0;
      valid_d        = 1'b0;
      repeat (2) begin
         @(posedge clk);
         @(negedge clk);
         check_reset_state();
      end
      @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_reset_state();
      @(posedge clk);

      // Start near a 4 KB boundary with a gappy stream
      phase = 1;
      configure(32'h0000_0F80);
      send_stream(PHASE1_WORDS, 1'b1);
      wait_drain();

      // Aligned start with continuous streaming
      phase = 2;
      configure(32'h0000_2000);
      send_stream(PHASE2_WORDS, 1'b0);
      wait_drain();

      $display("Errors: %0d, words checked: %0d, bursts checked: %0d", errors, words_checked,
               bursts_checked);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== dv/axi_mem_slave.sv ====
`timescale 1ns/100ps

module axi_mem_slave import axis2axi_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  axi_aw_t               aw_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  axi_w_t                w_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   output logic                  bvalid_o,
   input  logic                  bready_i,

   // Reports to the testbench, one cycle after the handshake
   output logic                  beat_o,
   output logic [AXI_ADDR_W-1:0] beat_addr_o,
   output logic [AXI_DATA_W-1:0] beat_data_o,
   output logic                  beat_last_o,
   output logic                  burst_o,
   output logic [AXI_ADDR_W-1:0] burst_addr_o,
   output logic [AXI_LEN_W-1:0]  burst_len_o,
   output logic [8:0]            burst_beats_o
);

   logic [AXI_DATA_W-1:0] mem [4096];
   logic [AXI_ADDR_W-1:0] base_addr_q;
   logic [AXI_LEN_W-1:0]  len_q;
   logic [8:0]            beat_cnt_q;
   logic                  b_pending_q;
   logic [1:0]            b_delay_q;
   logic [AXI_ADDR_W-1:0] beat_addr;

   assign beat_addr = base_addr_q + (AXI_ADDR_W'(beat_cnt_q) << 2);

   // Word memory
   always_ff @(posedge clk_i) begin
      if (wvalid_i && wready_o) begin
         mem[beat_addr[13:2]] <= w_i.data;
      end
   end

   // Reported data is read back from the word memory
   assign beat_data_o = mem[beat_addr_o[13:2]];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         awready_o     <= 1'b0;
         wready_o      <= 1'b0;
         bvalid_o      <= 1'b0;
         base_addr_q   <= '0;
         len_q         <= '0;
         beat_cnt_q    <= '0;
         b_pending_q   <= 1'b0;
         b_delay_q     <= '0;
         beat_o        <= 1'b0;
         beat_addr_o   <= '0;
         beat_last_o   <= 1'b0;
         burst_o       <= 1'b0;
         burst_addr_o  <= '0;
         burst_len_o   <= '0;
         burst_beats_o <= '0;
      end else begin
         // Stall roughly one cycle in four on each channel
         awready_o <= ($urandom_range(3, 0) != 0);
         wready_o  <= ($urandom_range(3, 0) != 0);
         beat_o    <= 1'b0;
         burst_o   <= 1'b0;
         if (awvalid_i && awready_o) begin
            base_addr_q <= aw_i.addr;
            len_q       <= aw_i.len;
            beat_cnt_q  <= '0;
         end
         if (wvalid_i && wready_o) begin
            beat_o      <= 1'b1;
            beat_addr_o <= beat_addr;
            beat_last_o <= w_i.last;
            beat_cnt_q  <= beat_cnt_q + 1'b1;
            if (w_i.last) begin
               burst_o       <= 1'b1;
               burst_addr_o  <= base_addr_q;
               burst_len_o   <= len_q;
               burst_beats_o <= beat_cnt_q + 1'b1;
               b_pending_q   <= 1'b1;
               b_delay_q     <= 2'($urandom_range(2, 0));
            end
         end
         // Response 1 to 3 cycles after the last beat
         if (b_pending_q) begin
            if (b_delay_q == '0) begin
               bvalid_o    <= 1'b1;
               b_pending_q <= 1'b0;
            end else begin
               b_delay_q <= b_delay_q - 1'b1;
            end
         end
         if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
         end
      end
   end

endmodule

// ==== source/axis2axi_in.sv ====
`timescale 1ns/100ps

module axis2axi_in import axis2axi_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // Configuration
   input  logic [AXI_ADDR_W-1:0] addr_i,
   input  logic                  set_config_i,

   // Stream input
   input  logic [AXI_DATA_W-1:0] axis_data_i,
   input  logic                  axis_valid_i,
   output logic                  axis_ready_o,

   // AXI master write port
   output axi_aw_t               aw_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output axi_w_t                w_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   input  logic                  bvalid_i,
   output logic                  bready_o,

   output logic                  busy_o
);

   logic                  fifo_full;
   logic                  fifo_wr;
   logic                  fifo_rd;
   logic [AXI_DATA_W-1:0] fifo_rdata;
   logic [BUFFER_W:0]     fifo_level;

   // Stream handshake maps straight onto the buffer
   assign fifo_wr      = axis_valid_i && !fifo_full;
   assign axis_ready_o = !fifo_full;

   stream_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .wr_i    (fifo_wr),
      .wdata_i (axis_data_i),
      .full_o  (fifo_full),
      .rd_i    (fifo_rd),
      .rdata_o (fifo_rdata),
      .empty_o (),
      .level_o (fifo_level)
   );

   axi_burst_writer u_writer (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .addr_i         (addr_i),
      .set_config_i   (set_config_i),
      .stream_valid_i (axis_valid_i),
      .fifo_level_i   (fifo_level),
      .fifo_rdata_i   (fifo_rdata),
      .fifo_rd_o      (fifo_rd),
      .aw_o           (aw_o),
      .awvalid_o      (awvalid_o),
      .awready_i      (awready_i),
      .w_o            (w_o),
      .wvalid_o       (wvalid_o),
      .wready_i       (wready_i),
      .bvalid_i       (bvalid_i),
      .bready_o       (bready_o),
      .busy_o         (busy_o)
   );

endmodule

// ==== source/axi_burst_writer.sv ====
`timescale 1ns/100ps

module axi_burst_writer import axis2axi_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // Configuration
   input  logic [AXI_ADDR_W-1:0] addr_i,
   input  logic                  set_config_i,

   // Stream and buffer side
   input  logic                  stream_valid_i,
   input  logic [BUFFER_W:0]     fifo_level_i,
   input  logic [AXI_DATA_W-1:0] fifo_rdata_i,
   output logic                  fifo_rd_o,

   // AXI write channels
   output axi_aw_t               aw_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output axi_w_t                w_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   input  logic                  bvalid_i,
   output logic                  bready_o,

   output logic                  busy_o
);

   typedef enum logic [1:0] {
      WAIT_DATA,
      START_TRANSFER,
      TRANSFER,
      WAIT_BRESP
   } state_t;

   state_t                state_q;
   state_t                state_d;
   logic [AXI_ADDR_W-1:0] cur_addr_q;
   logic [AXI_LEN_W-1:0]  len_q;
   logic [BURST_W-1:0]    beat_cnt_q;

   logic                  normal_burst;
   logic                  flush_burst;
   logic                  start_burst;
   logic [BURST_W:0]      avail_words;
   logic [BOUNDARY_W:0]   room_bytes;
   logic [BOUNDARY_W-2:0] room_words;
   logic [BURST_W:0]      burst_len;
   logic                  w_accept;
   logic                  last_beat;
   logic [AXI_ADDR_W-1:0] burst_bytes;
   logic [BOUNDARY_W:0]   aw_end;

   // Start conditions
   assign normal_burst = (fifo_level_i >= (BUFFER_W+1)'(BURST_SIZE));
   assign flush_burst  = (fifo_level_i != '0) && !normal_burst && !stream_valid_i;

   // A config strobe in the same cycle wins, the burst starts from the new address
   assign start_burst = (state_q == WAIT_DATA) && !set_config_i &&
                        (normal_burst || flush_burst);

   // Words available now; a flush takes whatever is buffered
   assign avail_words = normal_burst ? (BURST_W+1)'(BURST_SIZE) : fifo_level_i[BURST_W:0];

   // Words left before the next 4 KB boundary
   assign room_bytes = (BOUNDARY_W+1)'(BOUNDARY_BYTES) -
                       {1'b0, cur_addr_q[BOUNDARY_W-1:0]};
   assign room_words = room_bytes[BOUNDARY_W:2];

   always_comb begin
      if (room_words < {{(BOUNDARY_W-BURST_W-2){1'b0}}, avail_words}) begin
         burst_len = room_words[BURST_W:0];
      end else begin
         burst_len = avail_words;
      end
   end

   assign w_accept    = wvalid_o && wready_i;
   assign last_beat   = (beat_cnt_q == len_q[BURST_W-1:0]);
   assign burst_bytes = (AXI_ADDR_W'(len_q) + AXI_ADDR_W'(1)) << 2;

   // First read pre-loads beat 0, later reads follow each accepted beat
   assign fifo_rd_o = start_burst || (w_accept && !last_beat);

   // FSM
   always_comb begin
      state_d = state_q;
      case (state_q)
         WAIT_DATA: begin
            if (start_burst) begin
               state_d = START_TRANSFER;
            end
         end
         START_TRANSFER: begin
            if (awready_i) begin
               state_d = TRANSFER;
            end
         end
         TRANSFER: begin
            if (w_accept && last_beat) begin
               state_d = WAIT_BRESP;
            end
         end
         WAIT_BRESP: begin
            if (bvalid_i) begin
               state_d = WAIT_DATA;
            end
         end
         default: state_d = WAIT_DATA;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= WAIT_DATA;
      end else begin
         state_q <= state_d;
      end
   end

   // Address only moves between bursts so the AW payload stays put
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cur_addr_q <= '0;
      end else if (set_config_i && state_q == WAIT_DATA) begin
         cur_addr_q <= addr_i;
      end else if (w_accept && last_beat) begin
         cur_addr_q <= cur_addr_q + burst_bytes;
      end
   end

   // Burst length captured at start
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         len_q <= '0;
      end else if (start_burst) begin
         len_q <= AXI_LEN_W'(burst_len - 1'b1);
      end
   end

   // Beat counter
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beat_cnt_q <= '0;
      end else if (state_q == WAIT_DATA) begin
         beat_cnt_q <= '0;
      end else if (w_accept) begin
         beat_cnt_q <= beat_cnt_q + 1'b1;
      end
   end

   // Channel outputs
   assign awvalid_o  = (state_q == START_TRANSFER);
   assign aw_o.addr  = cur_addr_q;
   assign aw_o.len   = len_q;
   assign wvalid_o   = (state_q == TRANSFER);
   assign w_o.data   = fifo_rdata_i;
   assign w_o.last   = wvalid_o && last_beat;
   assign bready_o   = 1'b1;
   assign busy_o     = (state_q != WAIT_DATA);

   // End offset of the issued burst within its 4 KB page
   assign aw_end = {1'b0, aw_o.addr[BOUNDARY_W-1:0]} + burst_bytes[BOUNDARY_W:0];

   a_aw_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o)
   ) else $error("axi_burst_writer: AW dropped or changed before awready");

   // Buffered read data must hold while the slave stalls
   a_w_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wvalid_o && !wready_i |=> wvalid_o && $stable(w_o)
   ) else $error("axi_burst_writer: W dropped or changed before wready");

   a_no_4k_cross: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      awvalid_o |-> aw_end <= (BOUNDARY_W+1)'(BOUNDARY_BYTES)
   ) else $error("axi_burst_writer: burst crosses a 4 KB boundary");

endmodule

// ==== source/stream_fifo.sv ====
`timescale 1ns/100ps

module stream_fifo import axis2axi_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  wr_i,
   input  logic [AXI_DATA_W-1:0] wdata_i,
   output logic                  full_o,
   input  logic                  rd_i,
   output logic [AXI_DATA_W-1:0] rdata_o,
   output logic                  empty_o,
   output logic [BUFFER_W:0]     level_o
);

   logic [AXI_DATA_W-1:0] mem [BUFFER_SIZE];
   logic [BUFFER_W-1:0]   wr_ptr_q;
   logic [BUFFER_W-1:0]   rd_ptr_q;
   logic [BUFFER_W:0]     level_q;

   // Storage
   always_ff @(posedge clk_i) begin
      if (wr_i) begin
         mem[wr_ptr_q] <= wdata_i;
      end
   end

   // Read data lands one cycle after the strobe and holds until the next read
   always_ff @(posedge clk_i) begin
      if (rd_i) begin
         rdata_o <= mem[rd_ptr_q];
      end
   end

   // Pointers wrap naturally at the buffer size
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (wr_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // Level, simultaneous read and write leaves it unchanged
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         level_q <= '0;
      end else begin
         case ({wr_i, rd_i})
            2'b10: level_q <= level_q + 1'b1;
            2'b01: level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   assign level_o = level_q;
   assign full_o  = (level_q == (BUFFER_W+1)'(BUFFER_SIZE));
   assign empty_o = (level_q == '0);

   // Producer must respect full
   a_no_overflow: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wr_i |-> !full_o
   ) else $error("stream_fifo: write while full");

   // Burst writer never reads past what it sized
   a_no_underflow: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      rd_i |-> !empty_o
   ) else $error("stream_fifo: read while empty");

endmodule

// ==== source/axis2axi_pkg.sv ====
package axis2axi_pkg;

   // AXI master widths, only 4-byte beats are supported
   localparam int AXI_ADDR_W = 32;
   localparam int AXI_DATA_W = 32;
   localparam int AXI_LEN_W  = 8;

   // Largest burst, 16 beats
   localparam int BURST_W    = 4;
   localparam int BURST_SIZE = 2**BURST_W;

   // Stream buffer holds two full bursts
   localparam int BUFFER_W    = 5;
   localparam int BUFFER_SIZE = 2**BUFFER_W;

   // Bursts may not cross this boundary
   localparam int BOUNDARY_W     = 12;
   localparam int BOUNDARY_BYTES = 2**BOUNDARY_W;

   // Write address channel payload
   typedef struct packed {
      logic [AXI_ADDR_W-1:0] addr;
      logic [AXI_LEN_W-1:0]  len;
   } axi_aw_t;

   // Write data channel payload
   typedef struct packed {
      logic [AXI_DATA_W-1:0] data;
      logic                  last;
   } axi_w_t;

endpackage
